// File: Bender.yml
package:
  name: video_top

sources:
  - design/vid_pkg.sv
  - design/vram_bus_if.sv
  - design/bus_regs.sv
  - design/vram_arb.sv
  - design/video_fetch.sv
  - design/pixel_out.sv
  - design/intr_ctrl.sv
  - design/video_top.sv
  - target: simulation
    files:
      - verif/tb_video_top.sv

// File: design/bus_regs.sv
`timescale 1ns/1ps

module bus_regs import vid_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            bus_cs_n_i,     // active low select
    input  logic            bus_rd_nwr_i,   // 1 = read
    input  logic [3:0]      bus_reg_num_i,
    input  logic            bus_bytesel_i,  // 0 = even (high) byte
    input  logic [7:0]      bus_data_i,
    output logic [7:0]      bus_data_o,
    vram_bus_if.host        vram,
    output logic            pal_wr_o,
    output color_idx_t      pal_idx_o,
    output rgb_t            pal_data_o,
    output logic [7:0]      line_cmp_o,
    output intr_t           intr_mask_o,
    output intr_t           intr_clear_o,   // one clock strobe
    input  intr_t           intr_status_i
);

    logic       cs_q1;          // cs_n sampled
    logic       cs_q2;
    logic       strobe;         // one clock, just after cs_n fell
    logic       do_wr;          // odd byte write, full word ready
    logic       do_rd;
    logic       req_start;      // new vram request this clock
    logic [7:0] data_hi;        // even byte held for odd write
    word_t      wr_word;
    word_t      rd_word;
    word_t      line_cmp;
    word_t      rd_latch;       // last vram read
    vaddr_t     wr_addr;
    vaddr_t     rd_addr;
    color_idx_t pal_addr;

    assign strobe     = cs_q2 & ~cs_q1;
    assign do_wr      = strobe & ~bus_rd_nwr_i & bus_bytesel_i;
    assign do_rd      = strobe & bus_rd_nwr_i;
    assign wr_word    = {data_hi, bus_data_i};
    assign line_cmp_o = line_cmp[7:0];  // only low byte matters to video

    // data write, rd_addr write, odd data read all touch vram
    assign req_start  = (do_wr && (bus_reg_num_i == XM_DATA || bus_reg_num_i == XM_RD_ADDR))
                     || (do_rd && bus_bytesel_i && bus_reg_num_i == XM_DATA);

    always_comb begin
        case (bus_reg_num_i)
            XM_INT_CTRL: rd_word = {6'h00, intr_mask_o, 6'h00, intr_status_i};
            XM_LINE_CMP: rd_word = line_cmp;
            XM_WR_ADDR:  rd_word = {8'h00, wr_addr};
            XM_DATA:     rd_word = rd_latch;
            XM_RD_ADDR:  rd_word = {8'h00, rd_addr};
            XM_PAL_ADDR: rd_word = {12'h000, pal_addr};
            XM_PAL_DATA: rd_word = {4'h0, pal_data_o};     // last entry written
            default:     rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_q1        <= 1'b1;
            cs_q2        <= 1'b1;
            vram.sel     <= 1'b0;
            pal_wr_o     <= 1'b0;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
            line_cmp     <= '0;
            wr_addr      <= '0;
            rd_addr      <= '0;
            pal_addr     <= '0;
        end else begin
            cs_q1        <= bus_cs_n_i;
            cs_q2        <= cs_q1;
            pal_wr_o     <= 1'b0;
            intr_clear_o <= '0;
            if (vram.ack) begin
                vram.sel <= 1'b0;
            end
            if (req_start) begin
                vram.sel <= 1'b1;       // held until ack
            end
            if (do_wr) begin
                case (bus_reg_num_i)
                    XM_INT_CTRL: begin
                        intr_mask_o  <= wr_word[9:8];
                        intr_clear_o <= wr_word[1:0];   // write 1 to clear
                    end
                    XM_LINE_CMP: line_cmp <= wr_word;
                    XM_WR_ADDR:  wr_addr  <= wr_word[7:0];
                    XM_DATA:     wr_addr  <= wr_addr + 1'b1;
                    XM_RD_ADDR:  rd_addr  <= wr_word[7:0];
                    XM_PAL_ADDR: pal_addr <= wr_word[3:0];
                    XM_PAL_DATA: begin
                        pal_wr_o <= 1'b1;
                        pal_addr <= pal_addr + 1'b1;    // wraps at 16
                    end
                    default: ;
                endcase
            end
            if (do_rd && bus_bytesel_i && bus_reg_num_i == XM_DATA) begin
                rd_addr <= rd_addr + 1'b1;              // odd byte read advances
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobe && !bus_rd_nwr_i && !bus_bytesel_i) begin
            data_hi <= bus_data_i;
        end
        if (do_rd) begin
            bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
        end
        if (vram.ack && !vram.wr) begin
            rd_latch <= vram.rdata;
        end
        if (req_start) begin
            vram.wr    <= !bus_rd_nwr_i && bus_reg_num_i == XM_DATA;
            vram.wdata <= wr_word;
            if (bus_rd_nwr_i) begin
                vram.addr <= rd_addr + 1'b1;    // refetch next word
            end else if (bus_reg_num_i == XM_DATA) begin
                vram.addr <= wr_addr;
            end else begin
                vram.addr <= wr_word[7:0];
            end
        end
        if (do_wr && bus_reg_num_i == XM_PAL_DATA) begin
            pal_idx_o  <= pal_addr;
            pal_data_o <= wr_word[11:0];
        end
    end

    // one request at a time
    assert property (@(posedge clk) disable iff (reset_i) req_start |-> !vram.sel)
        else $error("vram request issued while one is pending");

    // arbiter serves host within a fetch slot
    assert property (@(posedge clk) disable iff (reset_i) $rose(vram.sel) |-> ##[1:4] vram.ack)
        else $error("vram ack did not arrive within 4 clocks");

endmodule

// File: design/intr_ctrl.sv
`timescale 1ns/1ps

module intr_ctrl import vid_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        vblank_start_i,
    input  logic        line_start_i,
    input  logic [7:0]  v_count_i,
    input  logic [7:0]  line_cmp_i,
    input  intr_t       intr_mask_i,
    input  intr_t       intr_clear_i,
    output intr_t       intr_status_o,  // sticky until cleared
    output logic        bus_intr_o
);

    intr_t events;

    always_comb begin
        events                = '0;
        events[INTR_VBLANK]   = vblank_start_i;
        events[INTR_LINE_CMP] = line_start_i && (v_count_i == line_cmp_i);
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status_o <= '0;
            bus_intr_o    <= 1'b0;
        end else begin
            // only new, enabled events reach the cpu
            bus_intr_o    <= |(events & intr_mask_i & ~intr_status_o);
            intr_status_o <= (intr_status_o & ~intr_clear_i) | events;  // event beats clear
        end
    end

endmodule

// File: design/pixel_out.sv
`timescale 1ns/1ps

module pixel_out import vid_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        pal_wr_i,
    input  color_idx_t  pal_idx_i,
    input  rgb_t        pal_data_i,
    input  color_idx_t  pix_i,
    input  logic        hsync_i,
    input  logic        vsync_i,
    input  logic        de_i,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

    rgb_t palette [16];
    rgb_t color;                // looked up, not yet blanked

    assign color = palette[pix_i];

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            palette[pal_idx_i] <= pal_data_i;
        end
    end

    // single stage keeps colour and syncs aligned
    always_ff @(posedge clk) begin
        if (reset_i) begin
            {red_o, green_o, blue_o} <= '0;
            hsync_o                  <= 1'b0;
            vsync_o                  <= 1'b0;
            dv_de_o                  <= 1'b0;
        end else begin
            {red_o, green_o, blue_o} <= de_i ? color : 12'h000;    // black in blank
            hsync_o                  <= hsync_i;
            vsync_o                  <= vsync_i;
            dv_de_o                  <= de_i;
        end
    end

endmodule

// File: design/vid_pkg.sv
package vid_pkg;

    typedef logic [15:0] word_t;        // vram or register word
    typedef logic [7:0]  vaddr_t;       // vram word address
    typedef logic [3:0]  color_idx_t;   // palette index
    typedef logic [11:0] rgb_t;         // 4 bits per gun, red on top
    typedef logic [1:0]  intr_t;        // one bit per source

    // same 16 bits, raw for the host, four pixels for video
    typedef union packed {
        word_t            raw;
        color_idx_t [3:0] pix;          // pix[3] is the leftmost pixel
    } vram_word_u;

    localparam int VRAM_WORDS     = 256;

    // horizontal timing, clocks
    localparam int H_ACTIVE       = 32;
    localparam int H_FRONT        = 2;
    localparam int H_SYNC         = 4;
    localparam int H_BACK         = 2;
    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing, lines
    localparam int V_ACTIVE       = 8;
    localparam int V_FRONT        = 1;
    localparam int V_SYNC         = 2;
    localparam int V_BACK         = 1;
    localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int WORDS_PER_LINE = H_ACTIVE / 4;  // four pixels per word

    // host register numbers
    localparam logic [3:0] XM_INT_CTRL = 4'd0;  // hi byte mask, lo byte status
    localparam logic [3:0] XM_LINE_CMP = 4'd1;
    localparam logic [3:0] XM_WR_ADDR  = 4'd2;
    localparam logic [3:0] XM_DATA     = 4'd3;
    localparam logic [3:0] XM_RD_ADDR  = 4'd4;
    localparam logic [3:0] XM_PAL_ADDR = 4'd5;
    localparam logic [3:0] XM_PAL_DATA = 4'd6;

    // interrupt bits
    localparam int INTR_VBLANK    = 0;
    localparam int INTR_LINE_CMP  = 1;

endpackage

// File: design/video_fetch.sv
`timescale 1ns/1ps

module video_fetch import vid_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    output logic        vid_sel_o,
    output vaddr_t      vid_addr_o,
    input  vram_word_u  vid_data_i,
    output color_idx_t  pix_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        de_o,
    output logic        vblank_start_o,
    output logic        line_start_o,
    output logic [7:0]  v_count_o
);

    logic [5:0] h_cnt;
    logic [3:0] v_cnt;
    logic       de_raw;
    logic       hs_raw;
    logic       vs_raw;
    logic [1:0] de_d;           // two clocks, fetch plus load
    logic [1:0] hs_d;
    logic [1:0] vs_d;
    logic       load;           // vid_data_i valid
    vram_word_u shreg;          // pixels shifting out, top nibble first

    assign de_raw = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign hs_raw = (h_cnt >= H_ACTIVE + H_FRONT) && (h_cnt < H_ACTIVE + H_FRONT + H_SYNC);
    assign vs_raw = (v_cnt >= V_ACTIVE + V_FRONT) && (v_cnt < V_ACTIVE + V_FRONT + V_SYNC);

    // one fetch every fourth clock of the active line
    assign vid_sel_o  = de_raw && (h_cnt[1:0] == 2'b00);
    assign vid_addr_o = vaddr_t'(v_cnt * WORDS_PER_LINE + (h_cnt >> 2));

    assign vblank_start_o = (h_cnt == 6'd0) && (v_cnt == V_ACTIVE);
    assign line_start_o   = (h_cnt == 6'd0);
    assign v_count_o      = {4'h0, v_cnt};

    assign pix_o   = shreg.pix[3];
    assign de_o    = de_d[1];
    assign hsync_o = hs_d[1];
    assign vsync_o = vs_d[1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
            load  <= 1'b0;
            de_d  <= '0;
            hs_d  <= '0;
            vs_d  <= '0;
        end else begin
            load <= vid_sel_o;
            de_d <= {de_d[0], de_raw};
            hs_d <= {hs_d[0], hs_raw};
            vs_d <= {vs_d[0], vs_raw};
            if (h_cnt == H_TOTAL - 1) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_TOTAL - 1) ? 4'd0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // next word lands right as the last nibble leaves
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= vid_data_i;
        end else begin
            shreg.pix <= {shreg.pix[2:0], 4'h0};
        end
    end

    assert property (@(posedge clk) disable iff (reset_i) de_o |-> !hsync_o)
        else $error("display enable high during hsync");

endmodule

// File: design/video_top.sv
`timescale 1ns/1ps

module video_top import vid_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_cs_n_i,
    input  logic        bus_rd_nwr_i,
    input  logic [3:0]  bus_reg_num_i,
    input  logic        bus_bytesel_i,
    input  logic [7:0]  bus_data_i,
    output logic [7:0]  bus_data_o,
    output logic        bus_intr_o,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o
);

    vram_bus_if vram_bus ();        // host side vram requests

    logic       vid_sel;
    vaddr_t     vid_addr;
    vram_word_u vid_data;
    logic       pal_wr;
    color_idx_t pal_idx;
    rgb_t       pal_data;
    logic [7:0] line_cmp;
    intr_t      intr_mask;
    intr_t      intr_clear;
    intr_t      intr_status;
    color_idx_t pix;
    logic       hsync;
    logic       vsync;
    logic       de;
    logic       vblank_start;
    logic       line_start;
    logic [7:0] v_count;

    bus_regs bus_regs_i (
        .clk(clk),                      .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i),        .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i),  .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),        .bus_data_o(bus_data_o),
        .vram(vram_bus.host),
        .pal_wr_o(pal_wr),              .pal_idx_o(pal_idx),
        .pal_data_o(pal_data),          .line_cmp_o(line_cmp),
        .intr_mask_o(intr_mask),        .intr_clear_o(intr_clear),
        .intr_status_i(intr_status)
    );

    vram_arb vram_arb_i (
        .clk(clk),
        .vid_sel_i(vid_sel),            .vid_addr_i(vid_addr),
        .vid_data_o(vid_data),          .host(vram_bus.arb)
    );

    video_fetch video_fetch_i (
        .clk(clk),                      .reset_i(reset_i),
        .vid_sel_o(vid_sel),            .vid_addr_o(vid_addr),
        .vid_data_i(vid_data),          .pix_o(pix),
        .hsync_o(hsync),                .vsync_o(vsync),
        .de_o(de),                      .vblank_start_o(vblank_start),
        .line_start_o(line_start),      .v_count_o(v_count)
    );

    pixel_out pixel_out_i (
        .clk(clk),                      .reset_i(reset_i),
        .pal_wr_i(pal_wr),              .pal_idx_i(pal_idx),
        .pal_data_i(pal_data),          .pix_i(pix),
        .hsync_i(hsync),                .vsync_i(vsync),
        .de_i(de),
        .red_o(red_o),                  .green_o(green_o),
        .blue_o(blue_o),                .hsync_o(hsync_o),
        .vsync_o(vsync_o),              .dv_de_o(dv_de_o)
    );

    intr_ctrl intr_ctrl_i (
        .clk(clk),                      .reset_i(reset_i),
        .vblank_start_i(vblank_start),  .line_start_i(line_start),
        .v_count_i(v_count),            .line_cmp_i(line_cmp),
        .intr_mask_i(intr_mask),        .intr_clear_i(intr_clear),
        .intr_status_o(intr_status),    .bus_intr_o(bus_intr_o)
    );

endmodule

// File: design/vram_arb.sv
`timescale 1ns/1ps

module vram_arb import vid_pkg::*; (
    input  logic    clk,
    input  logic    vid_sel_i,      // video always wins
    input  vaddr_t  vid_addr_i,
    output word_t   vid_data_o,     // one clock after vid_sel_i
    vram_bus_if.arb host
);

    word_t mem [VRAM_WORDS];
    logic  host_go;                 // host served this clock

    // skip the ack clock, sel is still high there
    assign host_go = host.sel & ~vid_sel_i & ~host.ack;

    always_ff @(posedge clk) begin
        host.ack <= host_go;
        if (vid_sel_i) begin
            vid_data_o <= mem[vid_addr_i];
        end
        if (host_go) begin
            if (host.wr) begin
                mem[host.addr] <= host.wdata;
            end
            host.rdata <= mem[host.addr];   // valid with ack
        end
    end

    assert property (@(posedge clk) host.ack |-> host.sel)
        else $error("vram ack without a pending request");

endmodule

// File: design/vram_bus_if.sv
`timescale 1ns/1ps

interface vram_bus_if import vid_pkg::*; ();

    logic   sel;        // request, held until ack
    logic   ack;        // single clock, rdata valid with it
    logic   wr;         // 1 = write
    vaddr_t addr;
    word_t  wdata;
    word_t  rdata;

    modport host (
        output sel, wr, addr, wdata,
        input  ack, rdata
    );

    modport arb (
        input  sel, wr, addr, wdata,
        output ack, rdata
    );

endinterface

// File: sim.f
design/vid_pkg.sv
design/vram_bus_if.sv
design/bus_regs.sv
design/vram_arb.sv
design/video_fetch.sv
design/pixel_out.sv
design/intr_ctrl.sv
design/video_top.sv
verif/tb_video_top.sv

// File: verif/tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top import vid_pkg::*; ();

    localparam int TIMEOUT = 2 * H_TOTAL * V_TOTAL;  // two frames of clocks
    localparam int NROWS   = 12;
    localparam int FRAME_WORDS = V_ACTIVE * WORDS_PER_LINE;

    typedef struct packed {
        logic       rd;         // 1 = read and compare
        logic [3:0] num;        // register number
        logic       bsel;       // 0 = even (high) byte
        logic [7:0] data;
        logic [7:0] exp;        // expected read byte
    } row_t;

    logic       clk;
    logic       reset;
    logic       cs_n;
    logic       rd_nwr;
    logic [3:0] reg_num;
    logic       bytesel;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       bus_intr;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    word_t      vram_model [FRAME_WORDS];
    rgb_t       pal_model [16];
    row_t       stim [NROWS];
    integer     seed;
    int         errors;
    int         pulses;
    int         i;
    logic [7:0] d;

    video_top video_top_i (
        .clk(clk),                  .reset_i(reset),
        .bus_cs_n_i(cs_n),          .bus_rd_nwr_i(rd_nwr),
        .bus_reg_num_i(reg_num),    .bus_bytesel_i(bytesel),
        .bus_data_i(wdata),         .bus_data_o(rdata),
        .bus_intr_o(bus_intr),
        .red_o(red),                .green_o(green),            .blue_o(blue),
        .hsync_o(hsync),            .vsync_o(vsync),            .dv_de_o(de)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns
    end

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // one byte cycle with cs_n low for 7 clocks then 16 idle
    task automatic bus_cycle(input logic rd, input logic [3:0] num, input logic bsel,
                             input logic [7:0] din, output logic [7:0] dout);
        @(posedge clk);
        cs_n    <= 1'b0;
        rd_nwr  <= rd;
        reg_num <= num;
        bytesel <= bsel;
        wdata   <= din;
        repeat (6) @(posedge clk);
        @(negedge clk) dout = rdata;    // stable well before cs_n rises
        @(posedge clk) cs_n <= 1'b1;
        repeat (16) @(posedge clk);
    endtask

    task automatic write_word(input logic [3:0] num, input logic [15:0] word);
        logic [7:0] unused;
        bus_cycle(1'b0, num, 1'b0, word[15:8], unused);    // even byte only latches
        bus_cycle(1'b0, num, 1'b1, word[7:0], unused);     // odd byte acts
    endtask

    task automatic read_check(input logic [3:0] num, input logic bsel, input logic [7:0] exp);
        logic [7:0] got;
        bus_cycle(1'b1, num, bsel, 8'h00, got);
        check_val("bus_data_o", got, exp);
    endtask

    function automatic logic probe(input int which);
        return (which == 0) ? vsync : bus_intr;
    endfunction

    // polls at falling edges until the first sample at level
    task automatic wait_for(input int which, input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (probe(which) !== level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (n < TIMEOUT) else begin
            errors++;
            $display("timed out waiting for %s", what);
        end
    endtask

    task automatic check_frame();
        int x;
        int y;
        int hs_w;
        int vs_w;
        int n;
        logic [3:0] idx;
        x    = 0;
        y    = 0;
        hs_w = 0;
        vs_w = 0;
        wait_for(0, 1'b1, "vsync_o to rise");
        wait_for(0, 1'b0, "vsync_o to fall");
        for (n = 0; n < H_TOTAL * V_TOTAL; n++) begin
            if (de && y < V_ACTIVE && x < H_ACTIVE) begin
                // leftmost pixel sits in the top nibble
                idx = 4'((vram_model[y * WORDS_PER_LINE + x / 4] >> (12 - 4 * (x % 4))));
                check_val("rgb", {red, green, blue}, pal_model[idx]);
                x++;
            end else if (de) begin
                x++;                    // overlong line caught at its end
            end else begin
                check_val("rgb in blank", {red, green, blue}, 12'h000);
                if (x != 0) begin
                    check_val("dv_de_o run length", x, H_ACTIVE);
                    y++;
                    x = 0;
                end
            end
            assert (!(de && hsync)) else begin
                errors++;
                $display("dv_de_o high during hsync_o at %0t", $time);
            end
            if (hsync) hs_w++;
            else if (hs_w != 0) begin
                check_val("hsync_o width", hs_w, H_SYNC);
                hs_w = 0;
            end
            if (vsync) vs_w++;      // whole pulse lies inside one frame window
            @(negedge clk);
        end
        check_val("active lines", y, V_ACTIVE);
        check_val("vsync_o width", vs_w, V_SYNC * H_TOTAL);
    endtask

    // pulse must be exactly one clock
    task automatic intr_pulse(input string what);
        wait_for(1, 1'b1, what);
        @(negedge clk);
        check_val("bus_intr_o width", bus_intr, 1'b0);
    endtask

    initial begin
        errors  = 0;
        seed    = 32'h8f82503c;
        reset   = 1'b1;
        cs_n    = 1'b1;
        rd_nwr  = 1'b0;
        reg_num = 4'h0;
        bytesel = 1'b0;
        wdata   = 8'h00;

        // rd, reg, byte, data, expected
        stim[0]  = '{1'b0, XM_LINE_CMP, 1'b0, 8'h12, 8'h00};
        stim[1]  = '{1'b0, XM_LINE_CMP, 1'b1, 8'h34, 8'h00};
        stim[2]  = '{1'b1, XM_LINE_CMP, 1'b0, 8'h00, 8'h12};
        stim[3]  = '{1'b1, XM_LINE_CMP, 1'b1, 8'h00, 8'h34};
        stim[4]  = '{1'b0, XM_INT_CTRL, 1'b0, 8'h03, 8'h00};   // mask both
        stim[5]  = '{1'b0, XM_INT_CTRL, 1'b1, 8'h00, 8'h00};
        stim[6]  = '{1'b1, XM_INT_CTRL, 1'b0, 8'h00, 8'h03};
        stim[7]  = '{1'b1, 4'd7,        1'b0, 8'h00, 8'h00};   // unused regs
        stim[8]  = '{1'b1, 4'd15,       1'b1, 8'h00, 8'h00};
        stim[9]  = '{1'b0, XM_INT_CTRL, 1'b0, 8'h00, 8'h00};   // mask off
        stim[10] = '{1'b0, XM_INT_CTRL, 1'b1, 8'h03, 8'h00};   // and clear
        stim[11] = '{1'b1, XM_INT_CTRL, 1'b0, 8'h00, 8'h00};

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        for (i = 0; i < NROWS; i++) begin
            bus_cycle(stim[i].rd, stim[i].num, stim[i].bsel, stim[i].data, d);
            if (stim[i].rd) check_val("bus_data_o", d, stim[i].exp);
        end

        // vram fill with auto increment then read back in order
        write_word(XM_WR_ADDR, 16'h0000);
        for (i = 0; i < FRAME_WORDS; i++) begin
            vram_model[i] = $random(seed);
            write_word(XM_DATA, vram_model[i]);
        end
        read_check(XM_WR_ADDR, 1'b1, 8'(FRAME_WORDS));
        write_word(XM_RD_ADDR, 16'h0000);
        for (i = 0; i < FRAME_WORDS; i++) begin
            read_check(XM_DATA, 1'b0, vram_model[i][15:8]);
            read_check(XM_DATA, 1'b1, vram_model[i][7:0]);     // advances rd addr
        end

        write_word(XM_PAL_ADDR, 16'h0000);
        for (i = 0; i < 16; i++) begin
            pal_model[i] = $random(seed);
            write_word(XM_PAL_DATA, {4'h0, pal_model[i]});
        end

        check_frame();

        // vblank masked in
        write_word(XM_INT_CTRL, 16'h0103);
        intr_pulse("vblank interrupt");
        read_check(XM_INT_CTRL, 1'b1, 8'h01);
        write_word(XM_INT_CTRL, 16'h0101);
        read_check(XM_INT_CTRL, 1'b1, 8'h00);

        // line compare on line 3 while vblank may also be pending
        write_word(XM_LINE_CMP, 16'h0003);
        write_word(XM_INT_CTRL, 16'h0203);
        intr_pulse("line compare interrupt");
        bus_cycle(1'b1, XM_INT_CTRL, 1'b1, 8'h00, d);
        check_val("line compare status", d & 8'h02, 8'h02);
        write_word(XM_INT_CTRL, 16'h0202);
        bus_cycle(1'b1, XM_INT_CTRL, 1'b1, 8'h00, d);
        check_val("line compare status", d & 8'h02, 8'h00);

        // both masked out but status still sets
        write_word(XM_INT_CTRL, 16'h0003);
        pulses = 0;
        for (i = 0; i < TIMEOUT; i++) begin
            @(negedge clk);
            if (bus_intr) pulses++;
        end
        check_val("bus_intr_o pulses", pulses, 0);
        read_check(XM_INT_CTRL, 1'b1, 8'h03);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
